//--- bus_monitor.sv
// SCL and SDA synchronizers with SCL edge pulses, stable-high level, START and STOP detection
`default_nettype none
`timescale 1ns/100ps

module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_posedge_o,
  output logic scl_negedge_o,
  output logic scl_stable_high_o,
  output logic sda_o,
  output logic start_o,
  output logic stop_o
);
  import i3c_pkg::*;

  logic [SYNC_STAGES-1:0] scl_sync_q;
  logic [SYNC_STAGES-1:0] sda_sync_q;
  logic                   scl_s;
  logic                   sda_s;
  logic                   scl_prev_q;
  logic                   sda_prev_q;

  assign scl_s = scl_sync_q[SYNC_STAGES-1];
  assign sda_s = sda_sync_q[SYNC_STAGES-1];

  // Bus lines idle high, so the chains come out of reset high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SYNC_STAGES-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
    end
  end

  assign scl_stable_high_o = scl_s & scl_prev_q;

  // Delayed copy of SDA lines up with the registered pulses
  assign sda_o = sda_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_posedge_o <= 1'b0;
      scl_negedge_o <= 1'b0;
      start_o       <= 1'b0;
      stop_o        <= 1'b0;
    end else begin
      scl_posedge_o <= scl_s & ~scl_prev_q;
      scl_negedge_o <= ~scl_s & scl_prev_q;
      // SDA moving while SCL is held high
      start_o       <= scl_stable_high_o & sda_prev_q & ~sda_s;
      stop_o        <= scl_stable_high_o & ~sda_prev_q & sda_s;
    end
  end

  a_start_stop_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(start_o && stop_o)
  );

endmodule

`default_nettype wire

//--- bus_rx_flow.sv
// Bus read flow taking one bit or one MSB-first byte per request
`default_nettype none
`timescale 1ns/100ps

module bus_rx_flow (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_posedge_i,
  input  logic                       scl_stable_high_i,
  input  logic                       sda_i,
  input  logic                       rx_req_bit_i,
  input  logic                       rx_req_byte_i,
  output logic [i3c_pkg::BYTE_W-1:0] rx_data_o,
  output logic                       rx_done_o,
  output logic                       rx_idle_o,
  output logic                       error_o
);
  import i3c_pkg::*;

  localparam int CNT_W = $clog2(BYTE_W);

  typedef enum logic [1:0] {
    RxIdle,
    RxReadByte,
    RxReadBit,
    RxNextTask
  } rx_state_e;

  rx_state_e         state_d;
  rx_state_e         state_q;
  logic [CNT_W-1:0]  bit_cnt_q;
  logic [BYTE_W-2:0] shift_q;
  logic              sample_q;
  logic              done_q;
  logic              sample_en;
  logic              cnt_en;
  logic              last_bit;
  logic              req;
  logic              req_bit_q;

  assign req      = rx_req_bit_i | rx_req_byte_i;
  assign error_o  = rx_req_bit_i & rx_req_byte_i;
  assign last_bit = (bit_cnt_q == '0) & done_q;

  // Bit requests are seen one cycle late
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_bit_q <= 1'b0;
    end else begin
      req_bit_q <= rx_req_bit_i;
    end
  end

  // One sample per SCL rise, taken once SCL reads high twice
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q   <= 1'b0;
      sample_q <= 1'b0;
    end else if (sample_en && scl_posedge_i && scl_stable_high_i) begin
      done_q   <= 1'b1;
      sample_q <= sda_i;
    end else begin
      done_q   <= 1'b0;
      sample_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q   <= '0;
      bit_cnt_q <= CNT_W'(BYTE_W - 1);
    end else if (!cnt_en) begin
      shift_q   <= '0;
      bit_cnt_q <= CNT_W'(BYTE_W - 1);
    end else if (done_q) begin
      shift_q   <= {shift_q[BYTE_W-3:0], sample_q};
      bit_cnt_q <= bit_cnt_q - 1'b1;
    end
  end

  always_comb begin
    if (state_q == RxReadBit) begin
      rx_data_o = {{(BYTE_W - 1){1'b0}}, sample_q};
    end else if ((state_q == RxReadByte) && last_bit) begin
      rx_data_o = {shift_q, sample_q};
    end else begin
      rx_data_o = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RxIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    rx_idle_o = 1'b0;
    rx_done_o = 1'b0;
    sample_en = 1'b0;
    cnt_en    = 1'b0;
    unique case (state_q)
      RxIdle: begin
        rx_idle_o = 1'b1;
      end
      RxReadByte: begin
        cnt_en    = 1'b1;
        sample_en = ~done_q;
        rx_done_o = last_bit;
      end
      RxReadBit: begin
        sample_en = ~done_q;
        rx_done_o = done_q;
      end
      RxNextTask: begin
        // Keep listening so a close SCL rise is not lost
        sample_en = req;
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RxIdle, RxNextTask: begin
        if (rx_req_byte_i) begin
          state_d = RxReadByte;
        end else if (req_bit_q) begin
          state_d = RxReadBit;
        end else begin
          state_d = RxIdle;
        end
      end
      RxReadByte: begin
        if (!rx_req_byte_i) begin
          state_d = RxIdle;
        end else if (rx_done_o) begin
          state_d = RxNextTask;
        end
      end
      RxReadBit: begin
        if (!rx_req_bit_i) begin
          state_d = RxIdle;
        end else if (done_q) begin
          state_d = RxNextTask;
        end
      end
      default: begin
        state_d = RxIdle;
      end
    endcase
    // Dropped or conflicting request aborts the read
    if (!req || error_o) begin
      state_d = RxIdle;
    end
  end

  a_done_with_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rx_done_o |-> req
  );

  a_single_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !error_o
  );

endmodule

`default_nettype wire

//--- bus_tx_flow.sv
// Open-drain ACK driver holding SDA low for one SCL period
`default_nettype none
`timescale 1ns/100ps

module bus_tx_flow (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_negedge_i,
  input  logic ack_req_i,
  output logic sda_oe_o,
  output logic busy_o
);

  typedef enum logic [1:0] {
    TxIdle,
    TxWaitLow,
    TxDriveAck
  } tx_state_e;

  tx_state_e state_d;
  tx_state_e state_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      TxIdle: begin
        if (ack_req_i) begin
          state_d = TxWaitLow;
        end
      end
      // SDA may only change while SCL is low
      TxWaitLow: begin
        if (scl_negedge_i) begin
          state_d = TxDriveAck;
        end
      end
      TxDriveAck: begin
        if (scl_negedge_i) begin
          state_d = TxIdle;
        end
      end
      default: begin
        state_d = TxIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= TxIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign sda_oe_o = (state_q == TxDriveAck);
  assign busy_o   = (state_q != TxIdle);

  a_no_req_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ack_req_i |-> !busy_o
  );

endmodule

`default_nettype wire

//--- i3c_pkg.sv
// Controller state enum and shared width and count constants for the I3C target receiver
`default_nettype none

package i3c_pkg;

  // Static address width, data byte width
  parameter int ADDR_W = 7;
  parameter int BYTE_W = 8;

  // Flops in each SCL and SDA synchronizer chain
  parameter int SYNC_STAGES = 2;

  // Target controller states
  typedef enum logic [2:0] {
    CtrlIdle,
    CtrlAddr,
    CtrlAck,
    CtrlData,
    CtrlTbit,
    CtrlIgnore
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- i3c_target_rx.f
i3c_pkg.sv
bus_monitor.sv
bus_rx_flow.sv
bus_tx_flow.sv
target_ctrl.sv
i3c_target_rx.sv
tb_i3c_target_rx.sv

//--- i3c_target_rx.sv
// Top level of the I3C private-write target receiver
`default_nettype none
`timescale 1ns/100ps

module i3c_target_rx #(
  parameter logic [i3c_pkg::ADDR_W-1:0] target_addr = 7'h2a
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  output logic                       sda_oe_o,
  output logic [i3c_pkg::BYTE_W-1:0] data_o,
  output logic                       data_valid_o,
  output logic                       parity_err_o,
  output logic                       addressed_o
);
  import i3c_pkg::*;

  logic              scl_posedge;
  logic              scl_negedge;
  logic              scl_stable_high;
  logic              sda_sync;
  logic              start_det;
  logic              stop_det;
  logic              rx_req_byte;
  logic              rx_req_bit;
  logic              rx_done;
  logic [BYTE_W-1:0] rx_data;
  logic              tx_ack_req;

  bus_monitor bus_monitor_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scl_i             (scl_i),
    .sda_i             (sda_i),
    .scl_posedge_o     (scl_posedge),
    .scl_negedge_o     (scl_negedge),
    .scl_stable_high_o (scl_stable_high),
    .sda_o             (sda_sync),
    .start_o           (start_det),
    .stop_o            (stop_det)
  );

  bus_rx_flow bus_rx_flow_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scl_posedge_i     (scl_posedge),
    .scl_stable_high_i (scl_stable_high),
    .sda_i             (sda_sync),
    .rx_req_bit_i      (rx_req_bit),
    .rx_req_byte_i     (rx_req_byte),
    .rx_data_o         (rx_data),
    .rx_done_o         (rx_done),
    .rx_idle_o         (),
    .error_o           ()
  );

  bus_tx_flow bus_tx_flow_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_negedge_i (scl_negedge),
    .ack_req_i     (tx_ack_req),
    .sda_oe_o      (sda_oe_o),
    .busy_o        ()
  );

  target_ctrl #(
    .target_addr (target_addr)
  ) target_ctrl_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_det),
    .stop_i        (stop_det),
    .rx_data_i     (rx_data),
    .rx_done_i     (rx_done),
    .rx_req_byte_o (rx_req_byte),
    .rx_req_bit_o  (rx_req_bit),
    .ack_req_o     (tx_ack_req),
    .data_o        (data_o),
    .data_valid_o  (data_valid_o),
    .parity_err_o  (parity_err_o),
    .addressed_o   (addressed_o)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_i3c_target_rx -f i3c_target_rx.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_i3c_target_rx > sim.log 2>&1; cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No pass message in log"; exit 1; }
exit 0

//--- target_ctrl.sv
// Target transfer FSM for address match, ACK, data bytes, T-bit parity and byte strobes
`default_nettype none
`timescale 1ns/100ps

module target_ctrl #(
  parameter logic [i3c_pkg::ADDR_W-1:0] target_addr = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       start_i,
  input  logic                       stop_i,
  input  logic [i3c_pkg::BYTE_W-1:0] rx_data_i,
  input  logic                       rx_done_i,
  output logic                       rx_req_byte_o,
  output logic                       rx_req_bit_o,
  output logic                       ack_req_o,
  output logic [i3c_pkg::BYTE_W-1:0] data_o,
  output logic                       data_valid_o,
  output logic                       parity_err_o,
  output logic                       addressed_o
);
  import i3c_pkg::*;

  ctrl_state_e       state_d;
  ctrl_state_e       state_q;
  logic [BYTE_W-1:0] byte_q;
  logic              bus_event;
  logic              addr_match;
  logic              parity_ok;

  assign bus_event = start_i | stop_i;

  // Address byte carries the 7-bit address above RnW, only writes are taken
  assign addr_match = (rx_data_i[BYTE_W-1 -: ADDR_W] == target_addr) && !rx_data_i[0];

  // Odd parity over the byte and its T-bit
  assign parity_ok = ^{byte_q, rx_data_i[0]};

  // Requests drop on a START or STOP so the read flow restarts clean
  assign rx_req_byte_o = ((state_q == CtrlAddr) || (state_q == CtrlData)) && !bus_event;
  assign rx_req_bit_o  = ((state_q == CtrlAck) || (state_q == CtrlTbit)) && !bus_event;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CtrlIdle, CtrlIgnore: ;
      CtrlAddr: begin
        if (rx_done_i) begin
          state_d = addr_match ? CtrlAck : CtrlIgnore;
        end
      end
      // ACK clock is read as one bit and thrown away
      CtrlAck: begin
        if (rx_done_i) begin
          state_d = CtrlData;
        end
      end
      CtrlData: begin
        if (rx_done_i) begin
          state_d = CtrlTbit;
        end
      end
      CtrlTbit: begin
        if (rx_done_i) begin
          state_d = CtrlData;
        end
      end
      default: begin
        state_d = CtrlIdle;
      end
    endcase
    if (start_i) begin
      state_d = CtrlAddr;
    end else if (stop_i) begin
      state_d = CtrlIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= CtrlIdle;
      ack_req_o    <= 1'b0;
      addressed_o  <= 1'b0;
      data_valid_o <= 1'b0;
      parity_err_o <= 1'b0;
      data_o       <= '0;
    end else begin
      state_q      <= state_d;
      ack_req_o    <= 1'b0;
      data_valid_o <= 1'b0;
      if (bus_event) begin
        addressed_o <= 1'b0;
      end else if (rx_done_i) begin
        if ((state_q == CtrlAddr) && addr_match) begin
          ack_req_o   <= 1'b1;
          addressed_o <= 1'b1;
        end
        if (state_q == CtrlTbit) begin
          data_valid_o <= 1'b1;
          data_o       <= byte_q;
          parity_err_o <= !parity_ok;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == CtrlData) && rx_done_i) begin
      byte_q <= rx_data_i;
    end
  end

endmodule

`default_nettype wire

//--- tb_i3c_target_rx.sv
// Testbench for the I3C target receiver with random private writes, bus model and checks
`default_nettype none
`timescale 1ns/100ps

module tb_i3c_target_rx;
  import i3c_pkg::*;

  localparam logic [ADDR_W-1:0] TARGET_ADDR = 7'h2a;
  localparam int NUM_XFERS = 20;
  // Transfers x frames x bits x clocks per bit, with margin
  localparam int TIMEOUT_CYCLES = NUM_XFERS * 6 * 9 * 16 * 2;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              scl_drv;
  logic              sda_drv;
  wire               sda_line;
  logic              sda_oe_o;
  logic [BYTE_W-1:0] data_o;
  logic              data_valid_o;
  logic              parity_err_o;
  logic              addressed_o;
  logic [31:0]       rnd;
  int                cycle_cnt = 0;
  logic [BYTE_W-1:0] got_data[$];
  logic              got_perr[$];

  // Open-drain SDA, the target can only pull it low
  assign sda_line = sda_drv & ~sda_oe_o;

  always #20 clk_i = ~clk_i;

  i3c_target_rx #(
    .target_addr (TARGET_ADDR)
  ) i3c_target_rx_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .scl_i        (scl_drv),
    .sda_i        (sda_line),
    .sda_oe_o     (sda_oe_o),
    .data_o       (data_o),
    .data_valid_o (data_valid_o),
    .parity_err_o (parity_err_o),
    .addressed_o  (addressed_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR time=%0t signal=%s expected=0x%0h actual=0x%0h",
               $time, name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // One SCL period with SDA set in the low phase, target drive sampled mid high phase
  task automatic clock_bit(input logic b, output logic oe_seen);
    scl_drv <= 1'b0;
    wait_clocks(2);
    sda_drv <= b;
    wait_clocks(6);
    scl_drv <= 1'b1;
    wait_clocks(4);
    @(negedge clk_i);
    oe_seen = sda_oe_o;
    wait_clocks(4);
  endtask

  task automatic shift_out_byte(input logic [BYTE_W-1:0] value);
    logic oe;
    for (int i = BYTE_W - 1; i >= 0; i--) begin
      clock_bit(value[i], oe);
      check_value("sda_oe_o", 1'b0, oe);
    end
  endtask

  // START or repeated START, SCL left high afterwards
  task automatic drive_start();
    scl_drv <= 1'b0;
    wait_clocks(4);
    sda_drv <= 1'b1;
    wait_clocks(4);
    scl_drv <= 1'b1;
    wait_clocks(8);
    sda_drv <= 1'b0;
    wait_clocks(8);
  endtask

  task automatic drive_stop();
    scl_drv <= 1'b0;
    wait_clocks(4);
    sda_drv <= 1'b0;
    wait_clocks(4);
    scl_drv <= 1'b1;
    wait_clocks(8);
    sda_drv <= 1'b1;
    wait_clocks(8);
  endtask

  task automatic check_strobes(input logic exp_addressed, input int exp_count,
                               input logic [BYTE_W-1:0] exp_data, input logic exp_perr);
    @(negedge clk_i);
    check_value("addressed_o", exp_addressed, addressed_o);
    check_value("data_valid_o pulses", exp_count, got_data.size());
    if (exp_count > 0) begin
      check_value("data_o", exp_data, got_data.pop_front());
      check_value("parity_err_o", exp_perr, got_perr.pop_front());
    end
    @(posedge clk_i);
  endtask

  task automatic run_transfer(input int idx, input logic need_start, output logic ended_sr);
    int                kind;
    int                nbytes;
    int                corrupt_idx;
    logic [ADDR_W-1:0] addr;
    logic              rnw;
    logic              match;
    logic              oe;
    logic [BYTE_W-1:0] data;
    logic              tbit;
    if (need_start) begin
      drive_start();
    end
    rnd = xorshift32(rnd);
    kind = (idx < 4) ? idx : int'(rnd % 4);
    rnd = xorshift32(rnd);
    case (kind)
      2: begin
        addr = rnd[ADDR_W-1:0];
        if (addr == TARGET_ADDR) begin
          addr = addr ^ 7'h01;
        end
        rnw = rnd[8];
      end
      3: begin
        addr = TARGET_ADDR;
        rnw  = 1'b1;
      end
      default: begin
        addr = TARGET_ADDR;
        rnw  = 1'b0;
      end
    endcase
    // Only a write to our own address is taken
    match = (addr == TARGET_ADDR) && !rnw;
    shift_out_byte({addr, rnw});
    // ACK clock with SDA released by the controller
    clock_bit(1'b1, oe);
    check_value("sda_oe_o", match, oe);
    check_strobes(match, 0, '0, 1'b0);
    rnd = xorshift32(rnd);
    nbytes = 1 + int'(rnd % 4);
    rnd = xorshift32(rnd);
    if (idx == 1) begin
      corrupt_idx = nbytes - 1;
    end else if (rnd[5:4] == 2'b00) begin
      corrupt_idx = int'(rnd[15:8]) % nbytes;
    end else begin
      corrupt_idx = -1;
    end
    for (int i = 0; i < nbytes; i++) begin
      rnd = xorshift32(rnd);
      data = rnd[BYTE_W-1:0];
      // T-bit makes the count of ones odd
      tbit = ~(^data);
      if (i == corrupt_idx) begin
        tbit = ~tbit;
      end
      shift_out_byte(data);
      clock_bit(tbit, oe);
      check_value("sda_oe_o", 1'b0, oe);
      check_strobes(match, match ? 1 : 0, data, i == corrupt_idx);
    end
    rnd = xorshift32(rnd);
    ended_sr = (idx < 2) || ((idx < NUM_XFERS - 1) && (rnd[2:0] < 3'd3));
    if (ended_sr) begin
      drive_start();
    end else begin
      drive_stop();
    end
    check_strobes(1'b0, 0, '0, 1'b0);
  endtask

  // Each byte strobe is queued for the checks
  always @(negedge clk_i) begin
    if (rst_ni && data_valid_o) begin
      got_data.push_back(data_o);
      got_perr.push_back(parity_err_o);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  initial begin
    logic need_start;
    logic ended_sr;
    rst_ni     = 1'b0;
    scl_drv    = 1'b1;
    sda_drv    = 1'b1;
    rnd        = 32'hc900;
    need_start = 1'b1;
    wait_clocks(8);
    rst_ni <= 1'b1;
    wait_clocks(4);
    @(negedge clk_i);
    check_value("sda_oe_o", 1'b0, sda_oe_o);
    check_value("data_valid_o", 1'b0, data_valid_o);
    check_value("addressed_o", 1'b0, addressed_o);
    check_value("parity_err_o", 1'b0, parity_err_o);
    check_value("data_o", '0, data_o);
    @(posedge clk_i);
    for (int i = 0; i < NUM_XFERS; i++) begin
      run_transfer(i, need_start, ended_sr);
      need_start = !ended_sr;
    end
    wait_clocks(16);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
